// ==== game_defs.svh ====
`ifndef GAME_DEFS_SVH
`define GAME_DEFS_SVH

// Screen size in pixels
`define SCREEN_W 320
`define SCREEN_H 240

// Player sprite
`define PLAYER_W    20
`define PLAYER_H    35
`define PLAYER_X0   30
`define PLAYER_Y0   37
`define PLAYER_STEP 5   // Pixels per move
`define GOAL_X      280 // Player wins at this column

// Enemy sprites
`define ENEMY_W    55
`define ENEMY_H    35
`define ENEMY_STEP 3
`define N_ENEMIES  2

// Enemy direction 0 is left and 1 is right
`define E0_Y    144
`define E0_XMIN 0
`define E0_XMAX 70
`define E0_X0   0       // Starts against its left bound
`define E0_DIR  0

`define E1_Y    189
`define E1_XMIN 107
`define E1_XMAX 265
`define E1_X0   265
`define E1_DIR  0

// PS/2 arrow codes
`define KEY_UP    8'h75
`define KEY_DOWN  8'h72
`define KEY_LEFT  8'h6B
`define KEY_RIGHT 8'h74

// Solid fill colors
`define COLOR_BG      3'd0
`define COLOR_PLAYER  3'd2
`define COLOR_ENEMY_L 3'd4
`define COLOR_ENEMY_R 3'd5

`endif

// ==== game_pkg.sv ====
`default_nettype none

package game_pkg;

	typedef logic [8:0] coord_t;    // Screen coordinate
	typedef logic [2:0] color_t;    // One bit per RGB channel

	// Top-left corner of a sprite
	typedef struct packed {
		coord_t x;
		coord_t y;
	} pos_t;

	// One framebuffer write
	typedef struct packed {
		coord_t x;
		coord_t y;
		color_t color;
	} pixel_t;

endpackage

`default_nettype wire

// ==== player_mover.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "game_defs.svh"

module player_mover (
	input  wire              clock,
	input  wire              reset,
	input  wire              move,
	input  wire logic [7:0]  key_data,
	input  wire              key_valid,
	output logic             key_ready,
	output game_pkg::pos_t   pos,
	output logic             moved,
	output logic             win
);
	import game_pkg::*;

	localparam coord_t X_LIMIT = coord_t'(`SCREEN_W - `PLAYER_W);
	localparam coord_t Y_LIMIT = coord_t'(`SCREEN_H - `PLAYER_H);
	localparam coord_t STEP    = coord_t'(`PLAYER_STEP);
	localparam coord_t GOAL    = coord_t'(`GOAL_X);

	logic       key_pending;
	logic [7:0] key_code;
	logic       is_arrow;
	logic       key_take;
	pos_t       next_pos;

	assign is_arrow = key_data == `KEY_UP || key_data == `KEY_DOWN ||
		key_data == `KEY_LEFT || key_data == `KEY_RIGHT;
	assign key_ready = !key_pending;
	assign key_take  = key_valid && key_ready;

	// Step in the pending direction, clamped to the screen
	always_comb begin
		next_pos = pos;
		if (key_pending) begin
			case (key_code)
				`KEY_LEFT:  next_pos.x = (pos.x < STEP) ? '0 : pos.x - STEP;
				`KEY_RIGHT: next_pos.x = (pos.x > X_LIMIT - STEP) ? X_LIMIT : pos.x + STEP;
				`KEY_UP:    next_pos.y = (pos.y < STEP) ? '0 : pos.y - STEP;
				`KEY_DOWN:  next_pos.y = (pos.y > Y_LIMIT - STEP) ? Y_LIMIT : pos.y + STEP;
				default:    next_pos = pos;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (!reset) begin
			key_pending <= 1'b0;
			pos.x       <= coord_t'(`PLAYER_X0);
			pos.y       <= coord_t'(`PLAYER_Y0);
			moved       <= 1'b0;
			win         <= 1'b0;
		end else begin
			moved <= move;
			if (move) begin
				pos         <= next_pos;
				key_pending <= 1'b0;
			end
			if (key_take && is_arrow)   // Non-arrow codes are dropped
				key_pending <= 1'b1;
			if (pos.x >= GOAL)
				win <= 1'b1;            // Sticky until reset
		end
	end

	always_ff @(posedge clock) begin
		if (key_take)
			key_code <= key_data;
	end

	assert property (@(posedge clock) disable iff (!reset)
		pos.x <= X_LIMIT && pos.y <= Y_LIMIT)
		else $error("player position left the screen");

endmodule

`default_nettype wire

// ==== enemy_patrol.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "game_defs.svh"

module enemy_patrol #(
	parameter int Y_ROW     = `E0_Y,
	parameter int X_MIN     = `E0_XMIN,
	parameter int X_MAX     = `E0_XMAX,
	parameter int X_START   = `E0_X0,
	parameter bit START_DIR = `E0_DIR
) (
	input  wire             clock,
	input  wire             reset,
	input  wire             move,
	input  wire game_pkg::pos_t player_pos,
	output game_pkg::pos_t  pos,
	output logic            dir,        // 1 moves right
	output logic            moved,
	output logic            hit
);
	import game_pkg::*;

	coord_t next_x;
	logic   next_dir;
	logic   overlap;

	// Bounce at either bound
	always_comb begin
		next_x   = pos.x;
		next_dir = dir;
		if (dir) begin
			if (int'(pos.x) + `ENEMY_STEP > X_MAX) begin
				next_x   = coord_t'(X_MAX);
				next_dir = 1'b0;
			end else begin
				next_x = pos.x + coord_t'(`ENEMY_STEP);
			end
		end else begin
			if (int'(pos.x) - `ENEMY_STEP < X_MIN) begin
				next_x   = coord_t'(X_MIN);
				next_dir = 1'b1;
			end else begin
				next_x = pos.x - coord_t'(`ENEMY_STEP);
			end
		end
	end

	// Rectangle intersection with the player
	assign overlap =
		int'(pos.x) < int'(player_pos.x) + `PLAYER_W &&
		int'(player_pos.x) < int'(pos.x) + `ENEMY_W &&
		int'(pos.y) < int'(player_pos.y) + `PLAYER_H &&
		int'(player_pos.y) < int'(pos.y) + `ENEMY_H;

	always_ff @(posedge clock) begin
		if (!reset) begin
			pos.x <= coord_t'(X_START);
			pos.y <= coord_t'(Y_ROW);
			dir   <= START_DIR;
			moved <= 1'b0;
			hit   <= 1'b0;
		end else begin
			moved <= move;
			if (move) begin
				pos.x <= next_x;
				dir   <= next_dir;
			end
			if (overlap)
				hit <= 1'b1;
		end
	end

	assert property (@(posedge clock) disable iff (!reset)
		int'(pos.x) >= X_MIN && int'(pos.x) <= X_MAX)
		else $error("enemy left its patrol range");

endmodule

`default_nettype wire

// ==== sprite_drawer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "game_defs.svh"

module sprite_drawer #(
	parameter int WIDTH  = `PLAYER_W,
	parameter int HEIGHT = `PLAYER_H
) (
	input  wire               clock,
	input  wire               reset,
	input  wire               moved,
	input  wire game_pkg::pos_t   new_pos,
	input  wire game_pkg::color_t color,
	input  wire               req_ready,
	output logic              req_valid,
	output game_pkg::pixel_t  req_pix,
	output logic              busy
);
	import game_pkg::*;

	localparam int CW = $clog2(WIDTH + 1);
	localparam int RW = $clog2(HEIGHT + 1);

	pos_t          old_pos;     // Last rectangle on screen
	pos_t          cur_pos;     // Rectangle of this frame
	pos_t          base;
	color_t        draw_color;
	logic          has_old;
	logic          erasing;
	logic [CW-1:0] col;
	logic [RW-1:0] row;
	logic          last_col;
	logic          last_row;
	logic          start;
	logic          step;

	assign start    = moved && !busy;
	assign step     = busy && req_ready;
	assign last_col = col == CW'(WIDTH - 1);
	assign last_row = row == RW'(HEIGHT - 1);

	assign base      = erasing ? old_pos : cur_pos;
	assign req_valid = busy;
	assign req_pix   = '{
		x:     base.x + coord_t'(col),
		y:     base.y + coord_t'(row),
		color: erasing ? color_t'(`COLOR_BG) : draw_color
	};

	// Row-major scan, erase pass then draw pass
	always_ff @(posedge clock) begin
		if (!reset) begin
			busy    <= 1'b0;
			erasing <= 1'b0;
			has_old <= 1'b0;
			col     <= '0;
			row     <= '0;
		end else if (start) begin
			busy    <= 1'b1;
			erasing <= has_old;     // Nothing to erase on the first frame
			col     <= '0;
			row     <= '0;
		end else if (step) begin
			if (!last_col) begin
				col <= col + 1'b1;
			end else begin
				col <= '0;
				if (!last_row) begin
					row <= row + 1'b1;
				end else begin
					row <= '0;
					if (erasing) begin
						erasing <= 1'b0;
					end else begin
						busy    <= 1'b0;
						has_old <= 1'b1;
					end
				end
			end
		end
	end

	always_ff @(posedge clock) begin
		if (start) begin
			cur_pos    <= new_pos;
			draw_color <= color;    // Enemy color after its move
		end
		if (step && last_col && last_row && !erasing)
			old_pos <= cur_pos;
	end

	assert property (@(posedge clock) disable iff (!reset)
		req_valid && !req_ready |=> req_valid && $stable(req_pix))
		else $error("drawer pixel changed before it was accepted");

endmodule

`default_nettype wire

// ==== pixel_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "game_defs.svh"

module pixel_arbiter #(
	parameter int N = `N_ENEMIES + 1
) (
	input  wire                   clock,
	input  wire                   reset,
	input  wire logic [N-1:0]     req_valid,
	input  wire game_pkg::pixel_t req_pix [N],
	input  wire                   pix_ready,
	output logic [N-1:0]          req_ready,
	output logic                  pix_valid,
	output game_pkg::pixel_t      pix
);
	import game_pkg::*;

	localparam int IW = (N > 1) ? $clog2(N) : 1;

	logic [IW-1:0] last_q;      // Last winner
	logic [IW-1:0] lock_idx;
	logic [IW-1:0] win_idx;
	logic          lock_q;      // Granted pixel still waiting
	logic          found;
	logic [N-1:0]  grant;
	pixel_t        win_pix;

	// Search starts one past the last winner
	always_comb begin
		int k;
		win_idx = lock_q ? lock_idx : last_q;
		found   = lock_q && req_valid[lock_idx];
		for (int i = 1; i <= N; i++) begin
			k = (int'(last_q) + i) % N;
			if (!found && req_valid[k]) begin
				win_idx = IW'(k);
				found   = 1'b1;
			end
		end
	end

	assign grant     = found ? (N'(1) << win_idx) : '0;
	assign win_pix   = req_pix[win_idx];
	assign pix_valid = found;
	assign pix       = win_pix;
	assign req_ready = grant & {N{pix_ready}};  // Ready only to the winner

	always_ff @(posedge clock) begin
		if (!reset) begin
			last_q <= IW'(N - 1);
			lock_q <= 1'b0;
		end else if (pix_valid && pix_ready) begin
			last_q <= win_idx;
			lock_q <= 1'b0;
		end else if (pix_valid) begin
			lock_q <= 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (pix_valid && !pix_ready)
			lock_idx <= win_idx;
	end

	// Stalled grant stays one-hot and on the same stream
	assert property (@(posedge clock) disable iff (!reset)
		pix_valid && !pix_ready |=> $onehot(grant) && $stable(grant))
		else $error("arbiter grant moved during a stall");

endmodule

`default_nettype wire

// ==== game_datapath.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "game_defs.svh"

module game_datapath (
	input  wire              clock,
	input  wire              reset,
	input  wire              frame_tick,
	input  wire logic [7:0]  key_data,
	input  wire              key_valid,
	input  wire              pix_ready,
	output logic             key_ready,
	output logic             pix_valid,
	output game_pkg::pixel_t pix,
	output logic             busy,
	output logic             win,
	output logic             lose
);
	import game_pkg::*;

	localparam int N_SPRITES = `N_ENEMIES + 1;     // Player is stream 0

	localparam int E_Y    [`N_ENEMIES] = '{`E0_Y, `E1_Y};
	localparam int E_XMIN [`N_ENEMIES] = '{`E0_XMIN, `E1_XMIN};
	localparam int E_XMAX [`N_ENEMIES] = '{`E0_XMAX, `E1_XMAX};
	localparam int E_X0   [`N_ENEMIES] = '{`E0_X0, `E1_X0};
	localparam bit E_DIR  [`N_ENEMIES] = '{`E0_DIR, `E1_DIR};

	logic                  move;
	pos_t                  player_pos;
	logic                  player_moved;
	pos_t                  enemy_pos [`N_ENEMIES];
	logic [`N_ENEMIES-1:0] enemy_dir;
	logic [`N_ENEMIES-1:0] enemy_moved;
	logic [`N_ENEMIES-1:0] enemy_hit;
	logic [N_SPRITES-1:0]  req_valid;
	logic [N_SPRITES-1:0]  req_ready;
	logic [N_SPRITES-1:0]  drawer_busy;
	pixel_t                req_pix [N_SPRITES];

	// Ticks while drawing or after the game ends are dropped
	assign move = frame_tick && !busy && !win && !lose;
	assign busy = |drawer_busy;
	assign lose = |enemy_hit;

	player_mover i_player_mover (
		.clock     (clock),
		.reset     (reset),
		.move      (move),
		.key_data  (key_data),
		.key_valid (key_valid),
		.key_ready (key_ready),
		.pos       (player_pos),
		.moved     (player_moved),
		.win       (win)
	);

	sprite_drawer #(.WIDTH(`PLAYER_W), .HEIGHT(`PLAYER_H)) i_player_drawer (
		.clock     (clock),
		.reset     (reset),
		.moved     (player_moved),
		.new_pos   (player_pos),
		.color     (color_t'(`COLOR_PLAYER)),
		.req_ready (req_ready[0]),
		.req_valid (req_valid[0]),
		.req_pix   (req_pix[0]),
		.busy      (drawer_busy[0])
	);

	for (genvar i = 0; i < `N_ENEMIES; i++) begin : g_enemy
		enemy_patrol #(
			.Y_ROW     (E_Y[i]),
			.X_MIN     (E_XMIN[i]),
			.X_MAX     (E_XMAX[i]),
			.X_START   (E_X0[i]),
			.START_DIR (E_DIR[i])
		) i_enemy_patrol (
			.clock      (clock),
			.reset      (reset),
			.move       (move),
			.player_pos (player_pos),
			.pos        (enemy_pos[i]),
			.dir        (enemy_dir[i]),
			.moved      (enemy_moved[i]),
			.hit        (enemy_hit[i])
		);

		sprite_drawer #(.WIDTH(`ENEMY_W), .HEIGHT(`ENEMY_H)) i_enemy_drawer (
			.clock     (clock),
			.reset     (reset),
			.moved     (enemy_moved[i]),
			.new_pos   (enemy_pos[i]),
			.color     (enemy_dir[i] ? color_t'(`COLOR_ENEMY_R) : color_t'(`COLOR_ENEMY_L)),
			.req_ready (req_ready[i+1]),
			.req_valid (req_valid[i+1]),
			.req_pix   (req_pix[i+1]),
			.busy      (drawer_busy[i+1])
		);
	end

	pixel_arbiter #(.N(N_SPRITES)) i_pixel_arbiter (
		.clock     (clock),
		.reset     (reset),
		.req_valid (req_valid),
		.req_pix   (req_pix),
		.pix_ready (pix_ready),
		.req_ready (req_ready),
		.pix_valid (pix_valid),
		.pix       (pix)
	);

endmodule

`default_nettype wire

// ==== tb_game_datapath.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "game_defs.svh"

module tb_game_datapath;
	import game_pkg::*;

	localparam int PIX_DRAW   = `PLAYER_W * `PLAYER_H + `N_ENEMIES * `ENEMY_W * `ENEMY_H;
	localparam int MAX_FRAMES = 80;
	localparam int LIMIT      = 4 * MAX_FRAMES * (2 * PIX_DRAW) * 2;  // Slack for back-pressure
	localparam int X_LIM      = `SCREEN_W - `PLAYER_W;
	localparam int Y_LIM      = `SCREEN_H - `PLAYER_H;

	localparam int EY   [`N_ENEMIES] = '{`E0_Y, `E1_Y};
	localparam int EXMIN[`N_ENEMIES] = '{`E0_XMIN, `E1_XMIN};
	localparam int EXMAX[`N_ENEMIES] = '{`E0_XMAX, `E1_XMAX};
	localparam int EX0  [`N_ENEMIES] = '{`E0_X0, `E1_X0};
	localparam int EDIR0[`N_ENEMIES] = '{`E0_DIR, `E1_DIR};

	logic       clock;
	logic       reset;
	logic       frame_tick;
	logic [7:0] key_data;
	logic       key_valid;
	logic       pix_ready;
	logic       key_ready;
	logic       pix_valid;
	pixel_t     pix;
	logic       busy;
	logic       win;
	logic       lose;

	logic [31:0] lfsr;
	int          cycles;

	// Reference model state
	int         m_px;
	int         m_py;
	int         m_ex [`N_ENEMIES];
	int         m_dir[`N_ENEMIES];   // 1 moves right
	int         o_px;                // Rectangles before the last move
	int         o_py;
	int         o_ex [`N_ENEMIES];
	logic       m_key_valid;
	logic [7:0] m_key;
	logic       m_active;
	logic       m_drawn;
	logic       m_erase;
	logic       m_win;
	logic       m_lose;
	int         m_left;              // Pixels still owed this frame

	logic   xfer;
	logic   in_player;
	logic   in_old;
	logic   enemy_ok;
	logic   prev_stall;
	logic   prev_busy;
	logic   prev_last;
	pixel_t prev_pix;

	game_datapath i_game_datapath (
		.clock      (clock),
		.reset      (reset),
		.frame_tick (frame_tick),
		.key_data   (key_data),
		.key_valid  (key_valid),
		.pix_ready  (pix_ready),
		.key_ready  (key_ready),
		.pix_valid  (pix_valid),
		.pix        (pix),
		.busy       (busy),
		.win        (win),
		.lose       (lose)
	);

	always #10 clock = ~clock;

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic is_arrow(input logic [7:0] code);
		return code == `KEY_UP || code == `KEY_DOWN || code == `KEY_LEFT || code == `KEY_RIGHT;
	endfunction

	function automatic logic inside_rect(input pixel_t p, input int x, input int y,
		input int w, input int h);
		return int'(p.x) >= x && int'(p.x) < x + w && int'(p.y) >= y && int'(p.y) < y + h;
	endfunction

	function automatic logic rects_overlap(input int ax, input int ay, input int bx, input int by);
		return ax < bx + `ENEMY_W && bx < ax + `PLAYER_W && ay < by + `ENEMY_H && by < ay + `PLAYER_H;
	endfunction

	task automatic value_error(input string name, input int expected, input int actual);
		$display("FAILED at %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
		$display("*** TEST FAILED ***");
		$fatal(1, "value mismatch on %s", name);
	endtask

	task automatic rule_error(input string what);
		$display("Error at %0t ns: %s", $time, what);
		$display("*** TEST FAILED ***");
		$fatal(1, "%s", what);
	endtask

	always @(posedge clock) begin
		#1;
		lfsr = lfsr_next(lfsr);
		pix_ready = lfsr[0];
	end

	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycles >= LIMIT) begin
			$display("Timeout after %0d cycles", cycles);
			$display("*** TEST FAILED ***");
			$fatal(1, "run exceeded its cycle limit");
		end
	end

	always_ff @(posedge clock) begin : model_update
		logic take;
		logic hit_now;
		take = frame_tick && !m_active && !m_win && !m_lose;
		hit_now = 1'b0;
		for (int i = 0; i < `N_ENEMIES; i++)
			if (rects_overlap(m_px, m_py, m_ex[i], EY[i]))
				hit_now = 1'b1;
		if (!reset) begin
			m_px        <= `PLAYER_X0;
			m_py        <= `PLAYER_Y0;
			m_key_valid <= 1'b0;
			m_active    <= 1'b0;
			m_drawn     <= 1'b0;
			m_erase     <= 1'b0;
			m_win       <= 1'b0;
			m_lose      <= 1'b0;
			m_left      <= 0;
			for (int i = 0; i < `N_ENEMIES; i++) begin
				m_ex[i]  <= EX0[i];
				m_dir[i] <= EDIR0[i];
			end
		end else begin
			m_win  <= m_win || m_px >= `GOAL_X;
			m_lose <= m_lose || hit_now;
			if (take) begin
				o_px     <= m_px;
				o_py     <= m_py;
				m_erase  <= m_drawn;
				m_drawn  <= 1'b1;
				m_active <= 1'b1;
				m_left   <= (m_drawn ? 2 : 1) * PIX_DRAW;
				m_key_valid <= 1'b0;
				if (m_key_valid) begin
					case (m_key)
						`KEY_LEFT:  m_px <= (m_px < `PLAYER_STEP) ? 0 : m_px - `PLAYER_STEP;
						`KEY_RIGHT: m_px <= (m_px + `PLAYER_STEP > X_LIM) ? X_LIM : m_px + `PLAYER_STEP;
						`KEY_UP:    m_py <= (m_py < `PLAYER_STEP) ? 0 : m_py - `PLAYER_STEP;
						`KEY_DOWN:  m_py <= (m_py + `PLAYER_STEP > Y_LIM) ? Y_LIM : m_py + `PLAYER_STEP;
						default:    ;
					endcase
				end
				for (int i = 0; i < `N_ENEMIES; i++) begin
					o_ex[i] <= m_ex[i];
					if (m_dir[i] != 0) begin
						if (m_ex[i] + `ENEMY_STEP > EXMAX[i]) begin
							m_ex[i]  <= EXMAX[i];
							m_dir[i] <= 0;
						end else begin
							m_ex[i] <= m_ex[i] + `ENEMY_STEP;
						end
					end else if (m_ex[i] - `ENEMY_STEP < EXMIN[i]) begin
						m_ex[i]  <= EXMIN[i];
						m_dir[i] <= 1;
					end else begin
						m_ex[i] <= m_ex[i] - `ENEMY_STEP;
					end
				end
			end
			if (xfer) begin
				m_left <= m_left - 1;
				if (m_left == 1)
					m_active <= 1'b0;   // Frame complete
			end
			if (key_valid && !m_key_valid && is_arrow(key_data)) begin
				m_key_valid <= 1'b1;
				m_key       <= key_data;
			end
		end
	end

	// Where the accepted pixel may lie
	always_comb begin
		xfer      = pix_valid && pix_ready;
		in_player = inside_rect(pix, m_px, m_py, `PLAYER_W, `PLAYER_H);
		in_old    = inside_rect(pix, o_px, o_py, `PLAYER_W, `PLAYER_H);
		enemy_ok  = 1'b0;
		for (int i = 0; i < `N_ENEMIES; i++) begin
			if (inside_rect(pix, o_ex[i], EY[i], `ENEMY_W, `ENEMY_H))
				in_old = 1'b1;
			if (inside_rect(pix, m_ex[i], EY[i], `ENEMY_W, `ENEMY_H) &&
				pix.color == (m_dir[i] != 0 ? `COLOR_ENEMY_R : `COLOR_ENEMY_L))
				enemy_ok = 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		prev_stall <= pix_valid && !pix_ready;
		prev_pix   <= pix;
		prev_busy  <= busy;
		prev_last  <= xfer && m_left == 1;
	end

	assert property (@(posedge clock) disable iff (!reset) key_ready == !m_key_valid)
		else value_error("key_ready", int'(!m_key_valid), int'(key_ready));
	assert property (@(posedge clock) disable iff (!reset) win == m_win)
		else value_error("win", int'(m_win), int'(win));
	assert property (@(posedge clock) disable iff (!reset) lose == m_lose)
		else value_error("lose", int'(m_lose), int'(lose));
	assert property (@(posedge clock) disable iff (!reset) prev_stall |-> pix == prev_pix)
		else value_error("pix", int'(prev_pix), int'(pix));
	assert property (@(posedge clock) disable iff (!reset) prev_stall |-> pix_valid)
		else rule_error("pix_valid dropped before the pixel was accepted");
	assert property (@(posedge clock) disable iff (!reset) pix_valid |-> m_left > 0)
		else rule_error("pixel offered with no frame in progress");
	assert property (@(posedge clock) disable iff (!reset) busy |-> m_active)
		else rule_error("busy high without an accepted tick");
	assert property (@(posedge clock) disable iff (!reset) prev_last |-> !busy)
		else rule_error("busy still high after the last pixel");
	assert property (@(posedge clock) disable iff (!reset) prev_busy && !busy |-> m_left == 0)
		else rule_error("busy fell before all pixels of the frame arrived");
	assert property (@(posedge clock) disable iff (!reset)
		xfer |-> int'(pix.x) < `SCREEN_W && int'(pix.y) < `SCREEN_H)
		else rule_error("accepted pixel lies off screen");
	assert property (@(posedge clock) disable iff (!reset)
		xfer && pix.color == `COLOR_PLAYER |-> in_player)
		else rule_error("player pixel outside the player rectangle");
	assert property (@(posedge clock) disable iff (!reset)
		xfer && pix.color == `COLOR_BG |-> m_erase && in_old)
		else rule_error("erase pixel outside every previous rectangle");
	assert property (@(posedge clock) disable iff (!reset)
		xfer && (pix.color == `COLOR_ENEMY_L || pix.color == `COLOR_ENEMY_R) |-> enemy_ok)
		else rule_error("enemy pixel off its rectangle or in the wrong direction color");
	assert property (@(posedge clock) disable iff (!reset)
		xfer |-> pix.color inside {`COLOR_BG, `COLOR_PLAYER, `COLOR_ENEMY_L, `COLOR_ENEMY_R})
		else rule_error("accepted pixel has an unknown color");

	task automatic hold_reset();
		reset = 1'b0;
		repeat (16) @(posedge clock);
		#1 reset = 1'b1;
	endtask

	task automatic send_key(input logic [7:0] code);
		key_data  = code;
		key_valid = 1'b1;
		@(negedge clock);
		while (!key_ready)
			@(negedge clock);
		@(posedge clock);
		#1 key_valid = 1'b0;
	endtask

	task automatic pulse_tick();
		frame_tick = 1'b1;
		@(posedge clock);
		#1 frame_tick = 1'b0;
	endtask

	task automatic run_frame();
		pulse_tick();
		while (m_active) begin
			@(posedge clock);
			#1;
		end
	endtask

	// Second tick lands in the middle of drawing
	task automatic tick_while_busy();
		pulse_tick();
		while (!busy) begin
			@(posedge clock);
			#1;
		end
		pulse_tick();
		while (m_active) begin
			@(posedge clock);
			#1;
		end
	endtask

	task automatic drop_tick();
		pulse_tick();
		repeat (8) begin
			@(posedge clock);
			#1;
		end
	endtask

	initial begin
		clock      = 1'b0;
		frame_tick = 1'b0;
		key_data   = 8'h00;
		key_valid  = 1'b0;
		pix_ready  = 1'b0;
		lfsr       = 32'h7b3d_f385;
		cycles     = 0;
		hold_reset();
		run_frame();            // Draw pass only
		repeat (4) begin
			send_key(`KEY_RIGHT);
			run_frame();
		end
		send_key(`KEY_RIGHT);
		tick_while_busy();
		send_key(8'h1C);        // Not an arrow
		run_frame();
		hold_reset();
		while (!lose) begin
			send_key(`KEY_DOWN);
			run_frame();
		end
		drop_tick();
		hold_reset();
		while (!win) begin
			send_key(`KEY_RIGHT);
			run_frame();
		end
		drop_tick();
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+.
game_pkg.sv
player_mover.sv
enemy_patrol.sv
sprite_drawer.sv
pixel_arbiter.sv
game_datapath.sv
tb_game_datapath.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the game datapath testbench with Verilator
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
	-f build.f --top-module tb_game_datapath -o sim_game
if [ $? -ne 0 ]; then
	echo "Verilator compile failed"
	exit 1
fi

./obj_dir/sim_game > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qF "*** TEST FAILED ***" sim.log; then
	exit 1
fi
exit 0
